// File: vlog.f
design/sdmac_pkg.sv
design/dma_if.sv
design/sdmac_regs.sv
design/byte_packer.sv
design/word_fifo.sv
design/host_master.sv
design/sdmac_top.sv
sim/tb_sdmac.sv

// File: run.sh
#!/bin/sh
# Build and run the SDMAC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_sdmac -f vlog.f

out=$(./obj_dir/Vtb_sdmac)
echo "$out"
echo "$out" | grep -qx "TEST OK"

// File: sim/tb_sdmac.sv
/* SDMAC testbench
   Table-driven CPU, peripheral and memory stimulus with a reference write list */
`timescale 1ns/1ps

module tb_sdmac import sdmac_pkg::*; ();

  localparam int NCASES = 7;

  // Case table, one column per field
  localparam logic [31:0] T_ADDR [NCASES] = '{32'h0000_1000, 32'h0000_2004, 32'h0000_3000,
                                             32'h0000_4008, 32'h0000_5003, 32'h0000_6000,
                                             32'h0000_7000};
  localparam int T_BYTES [NCASES] = '{16, 7, 40, 10, 13, 48, 8};
  localparam bit T_FLUSH [NCASES] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
  localparam int T_STALL [NCASES] = '{0, 20, 70, 30, 0, 10, 40}; // Percent of cycles
  localparam bit T_INTEN [NCASES] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
  localparam bit T_HOLD  [NCASES] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0}; // Long stall

  logic        CLK = 1'b0;
  logic        RST_;
  logic [7:0]  addr;
  logic        dmac_;
  logic        as_;
  logic        rw;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        dsack_;
  logic        int_;
  logic        preset;
  logic        per_valid;
  logic [7:0]  per_byte;
  logic        per_ready;
  logic        mem_ack;
  logic        mem_req;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_be;

  integer      seed = 32'h2cadf4fa;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          stall_pct = 0;   // Memory stall rate of the running case
  logic        hold_ack = 1'b0; // Forces mem_ack low
  logic [7:0]  stim [64];       // Bytes of the running case
  logic [31:0] rec_addr [$];    // Writes seen by the memory model
  logic [31:0] rec_data [$];
  logic [3:0]  rec_be [$];

  sdmac_top #(.FIFO_DEPTH(8)) dut0 (
    .CLK       (CLK),
    .RST_      (RST_),
    .addr      (addr),
    .dmac_     (dmac_),
    .as_       (as_),
    .rw        (rw),
    .wdata     (wdata),
    .rdata     (rdata),
    .dsack_    (dsack_),
    .int_      (int_),
    .preset    (preset),
    .per_valid (per_valid),
    .per_byte  (per_byte),
    .per_ready (per_ready),
    .mem_ack   (mem_ack),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_be    (mem_be)
  );

  always #20 CLK = ~CLK; // 40 ns period

  // Memory model, ack driven on the falling edge and taken at the next rising edge
  always @(negedge CLK) begin : mem_model
    int rnd;
    if (mem_req && !mem_ack && !hold_ack) begin
      rnd = $random(seed);
      if ((rnd & 32'h7fff_ffff) % 100 >= stall_pct) begin
        mem_ack = 1'b1;
        rec_addr.push_back(mem_addr); // Stable while mem_req is high
        rec_data.push_back(mem_wdata);
        rec_be.push_back(mem_be);
      end else begin
        mem_ack = 1'b0;
      end
    end else begin
      mem_ack = 1'b0;
    end
  end

  // Watchdog sized from the table
  initial begin : watchdog
    int limit;
    limit = 200;
    for (int i = 0; i < NCASES; i++)
      limit = limit + 20 * T_BYTES[i];
    repeat (limit) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the run did not complete", limit);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // One CPU bus cycle, held until DSACK, then released
  task automatic cpu_cycle(input logic [7:0] a, input logic wr, input logic [31:0] d,
                           output logic [31:0] q);
    int n;
    @(negedge CLK);
    addr  = a;
    rw    = ~wr;
    wdata = d;
    dmac_ = 1'b0;
    as_   = 1'b0;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (dsack_ && n < 20);
    if (dsack_) begin
      $display("No bus termination for the access to offset %h", a);
      err_cnt++;
    end
    q     = rdata;
    as_   = 1'b1;
    dmac_ = 1'b1;
    rw    = 1'b1;
    n = 0;
    while (!dsack_ && n < 20) begin
      @(negedge CLK);
      n++;
    end
  endtask

  task automatic cpu_write(input logic [7:0] a, input logic [31:0] d);
    logic [31:0] q;
    cpu_cycle(a, 1'b1, d, q);
  endtask

  task automatic cpu_read(input logic [7:0] a, output logic [31:0] q);
    cpu_cycle(a, 1'b0, 32'h0, q);
  endtask

  // Offer bytes until all are taken, per_ready sampled mid low phase
  task automatic feed_bytes(input int n);
    int i;
    i = 0;
    while (i < n) begin
      @(negedge CLK);
      per_valid = 1'b1;
      per_byte  = stim[i];
      #5;
      if (per_ready)
        i++; // Taken at the next rising edge
    end
    @(negedge CLK);
    per_valid = 1'b0;
  endtask

  // Runs beside feed_bytes while the memory holds mem_ack low
  task automatic probe_backpressure();
    int n;
    logic [31:0] q;
    n = 0;
    do begin
      @(negedge CLK);
      #5;
      n++;
    end while (per_ready && n < 200);
    if (per_ready) begin
      $display("per_ready never dropped during the forced memory stall");
      err_cnt++;
    end
    cpu_read(REG_ISTR, q);
    check_value("istr.ff", 32'(q[ISTR_FF]), 32'h1);
    @(negedge CLK);
    #5;
    check_value("per_ready", 32'(per_ready), 32'h0); // Still stalled
    hold_ack = 1'b0;
  endtask

  // Wait for the flush interrupt or for all writes, then for WTC to settle
  task automatic wait_drain(input int c, input int exp_n);
    int n;
    int limit;
    limit = 100 + 20 * T_BYTES[c];
    n = 0;
    if (T_FLUSH[c] && T_INTEN[c]) begin
      while (int_ && n < limit) begin
        @(negedge CLK);
        n++;
      end
      if (int_) begin
        $display("Case %0d timed out waiting for the flush interrupt", c);
        err_cnt++;
      end
    end else begin
      while (rec_addr.size() < exp_n && n < limit) begin
        @(negedge CLK);
        n++;
      end
      if (rec_addr.size() < exp_n) begin
        $display("Case %0d timed out waiting for %0d memory writes", c, exp_n);
        err_cnt++;
      end
    end
    while (mem_req && n < limit) begin
      @(negedge CLK);
      n++;
    end
    repeat (2) @(negedge CLK); // word_done, then WTC and flush done
  endtask

  // Reference writes from the stimulus, packing and address rules
  task automatic check_writes(input int c, input int exp_n);
    logic [31:0] base;
    logic [31:0] exp_w;
    logic [3:0]  exp_be;
    int          idx;
    base = {T_ADDR[c][31:2], 2'b00};
    check_value("mem write count", 32'(rec_addr.size()), 32'(exp_n));
    for (int k = 0; k < exp_n && k < rec_addr.size(); k++) begin
      exp_w  = '0;
      exp_be = '0;
      for (int j = 0; j < 4; j++) begin
        idx = 4 * k + j;
        if (idx < T_BYTES[c]) begin
          exp_w[31 - 8 * j -: 8] = stim[idx]; // First byte in the top lane
          exp_be[3 - j]          = 1'b1;
        end
      end
      check_value($sformatf("mem_addr[%0d]", k), rec_addr[k], base + 32'(4 * k));
      check_value($sformatf("mem_wdata[%0d]", k), rec_data[k], exp_w);
      check_value($sformatf("mem_be[%0d]", k), 32'(rec_be[k]), 32'(exp_be));
    end
  endtask

  task automatic report(input string name, input int err_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("%s: pass", name);
    end else begin
      fail_cnt++;
      $display("%s: fail, %0d errors", name, err_cnt - err_before);
    end
  endtask

  initial begin : main
    int          err_before;
    int          exp_n;
    int          stop_writes;
    logic        pre;
    logic [31:0] cntr_val;
    logic [31:0] exp;
    logic [31:0] q;
    RST_      = 1'b0;
    addr      = 8'h00;
    dmac_     = 1'b1;
    as_       = 1'b1;
    rw        = 1'b1;
    wdata     = 32'h0;
    per_valid = 1'b0;
    per_byte  = 8'h00;
    mem_ack   = 1'b0;
    repeat (4) @(negedge CLK);
    RST_ = 1'b1;

    // Reset state
    err_before = err_cnt;
    check_value("per_ready", 32'(per_ready), 32'h0);
    check_value("mem_req", 32'(mem_req), 32'h0);
    check_value("int_", 32'(int_), 32'h1);
    check_value("dsack_", 32'(dsack_), 32'h1);
    check_value("preset", 32'(preset), 32'h0);
    cpu_read(REG_WTC, q);
    check_value("wtc", q, 32'h0);
    report("reset state", err_before);

    for (int c = 0; c < NCASES; c++) begin
      err_before = err_cnt;
      exp_n      = T_FLUSH[c] ? (T_BYTES[c] + 3) / 4 : T_BYTES[c] / 4;
      for (int i = 0; i < T_BYTES[c]; i++)
        stim[i] = 8'($random(seed));
      rec_addr.delete();
      rec_data.delete();
      rec_be.delete();
      stall_pct = T_STALL[c];
      pre       = c[0]; // Preset toggles from case to case

      cpu_write(REG_ACR, T_ADDR[c]);
      cntr_val              = '0;
      cntr_val[CNTR_INTEN]  = T_INTEN[c];
      cntr_val[CNTR_PRESET] = pre;
      cpu_write(REG_CNTR, cntr_val);
      check_value("preset", 32'(preset), 32'(pre));
      cpu_write(REG_ST_DMA, 32'h0);
      cpu_read(REG_CNTR, q);
      exp              = cntr_val;
      exp[CNTR_DMAENA] = 1'b1;
      check_value("cntr", q, exp);

      if (T_HOLD[c]) begin
        hold_ack = 1'b1;
        fork
          feed_bytes(T_BYTES[c]);
          probe_backpressure();
        join
      end else begin
        feed_bytes(T_BYTES[c]);
      end
      if (T_FLUSH[c])
        cpu_write(REG_FLUSH, 32'h0);
      wait_drain(c, exp_n);
      check_writes(c, exp_n);

      cpu_read(REG_WTC, q);
      check_value("wtc", q, 32'(exp_n));
      cpu_read(REG_ISTR, q);
      check_value("istr.fe", 32'(q[ISTR_FE]), 32'h1);
      check_value("istr.ff", 32'(q[ISTR_FF]), 32'h0);
      check_value("istr.int_f", 32'(q[ISTR_INT_F]), 32'(T_FLUSH[c]));
      check_value("istr.int_p", 32'(q[ISTR_INT_P]), 32'(T_FLUSH[c]));
      check_value("int_", 32'(int_), 32'(!(T_FLUSH[c] && T_INTEN[c])));
      if (T_FLUSH[c]) begin
        cpu_write(REG_CLR_INT, 32'h0);
        cpu_read(REG_ISTR, q);
        check_value("istr.int_f", 32'(q[ISTR_INT_F]), 32'h0);
        check_value("istr.int_p", 32'(q[ISTR_INT_P]), 32'h0);
        check_value("int_", 32'(int_), 32'h1);
      end
      report($sformatf("case %0d, %0d bytes, %0d words", c, T_BYTES[c], exp_n), err_before);
    end

    // Unmapped offsets, read while WTC and CNTR hold nonzero values
    err_before = err_cnt;
    cpu_read(8'h00, q);
    check_value("rdata@00", q, 32'h0);
    cpu_read(8'h24, q);
    check_value("rdata@24", q, 32'h0);
    cpu_read(8'hFC, q);
    check_value("rdata@fc", q, 32'h0);
    report("unmapped reads", err_before);

    // Stop DMA, bytes still offered but nothing moves
    err_before  = err_cnt;
    stall_pct   = 0;
    stop_writes = rec_addr.size();
    cpu_write(REG_SP_DMA, 32'h0);
    cpu_read(REG_CNTR, q);
    check_value("cntr.dmaena", 32'(q[CNTR_DMAENA]), 32'h0);
    for (int i = 0; i < 20; i++) begin
      @(negedge CLK);
      per_valid = 1'b1;
      per_byte  = 8'($random(seed));
      #5;
      check_value("per_ready", 32'(per_ready), 32'h0);
    end
    @(negedge CLK);
    per_valid = 1'b0;
    repeat (4) @(negedge CLK);
    check_value("mem write count", 32'(rec_addr.size()), 32'(stop_writes));
    report("stop dma", err_before);

    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: design/sdmac_top.sv
/* SDMAC top level
   Register block beside the packer, FIFO and bus master data path */
`timescale 1ns/1ps

module sdmac_top #(
  parameter int FIFO_DEPTH = 8 // Power of two, 2 to 32
) (
  input  logic        CLK,
  input  logic        RST_,
  // CPU bus
  input  logic [7:0]  addr,
  input  logic        dmac_,
  input  logic        as_,
  input  logic        rw,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic        dsack_,
  output logic        int_,
  output logic        preset,
  // Peripheral side
  input  logic        per_valid,
  input  logic [7:0]  per_byte,
  output logic        per_ready,
  // Memory side
  input  logic        mem_ack,
  output logic        mem_req,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  output logic [3:0]  mem_be
);

  logic        dma_ena;
  logic        flush_req;
  logic        acr_load;
  logic [31:0] acr_value;
  logic        fifo_empty;
  logic        fifo_full;
  logic        master_idle;
  logic        word_done;
  logic        packer_empty;

  dma_if pk2ff (); // Packer to FIFO, FIFO_DEPTH credits
  dma_if ff2hm (); // FIFO to master, 2 credits

  sdmac_regs u_regs (
    .CLK          (CLK),
    .RST_         (RST_),
    .addr         (addr),
    .dmac_        (dmac_),
    .as_          (as_),
    .rw           (rw),
    .wdata        (wdata),
    .rdata        (rdata),
    .dsack_       (dsack_),
    .int_         (int_),
    .preset       (preset),
    .dma_ena      (dma_ena),
    .flush_req    (flush_req),
    .acr_load     (acr_load),
    .acr_value    (acr_value),
    .fifo_empty   (fifo_empty),
    .fifo_full    (fifo_full),
    .master_idle  (master_idle),
    .word_done    (word_done),
    .packer_empty (packer_empty)
  );

  byte_packer #(.FIFO_DEPTH(FIFO_DEPTH)) u_packer (
    .CLK          (CLK),
    .RST_         (RST_),
    .dma_ena      (dma_ena),
    .flush_req    (flush_req),
    .per_valid    (per_valid),
    .per_byte     (per_byte),
    .per_ready    (per_ready),
    .packer_empty (packer_empty),
    .out          (pk2ff.src)
  );

  word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .CLK        (CLK),
    .RST_       (RST_),
    .in         (pk2ff.dst),
    .out        (ff2hm.src),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full)
  );

  host_master u_master (
    .CLK         (CLK),
    .RST_        (RST_),
    .dma_ena     (dma_ena),
    .acr_load    (acr_load),
    .acr_value   (acr_value),
    .mem_ack     (mem_ack),
    .in          (ff2hm.dst),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_be      (mem_be),
    .master_idle (master_idle),
    .word_done   (word_done)
  );

endmodule

// File: design/host_master.sv
/* Host bus master
   Two-word holding buffer, writes to memory at ascending word addresses */
`timescale 1ns/1ps

module host_master import sdmac_pkg::*; (
  input  logic        CLK,
  input  logic        RST_,
  input  logic        dma_ena,
  input  logic        acr_load,
  input  logic [31:0] acr_value,
  input  logic        mem_ack,
  dma_if.dst          in,
  output logic        mem_req,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  output logic [3:0]  mem_be,
  output logic        master_idle,
  output logic        word_done
);

  dma_word_u  hold_w [2]; // Held words
  lane_t      hold_l [2]; // Their lanes
  logic       wr_idx;
  logic       rd_idx;     // Head entry
  logic [1:0] cnt;        // Entries held, 0 to 2
  logic       start;      // Begin a write from the head
  logic       done;       // Write accepted by memory

  assign start       = dma_ena & ~mem_req & (cnt != 2'd0);
  assign done        = mem_req & mem_ack;
  assign master_idle = (cnt == 2'd0);

  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      wr_idx    <= 1'b0;
      rd_idx    <= 1'b0;
      cnt       <= 2'd0;
      mem_req   <= 1'b0;
      mem_addr  <= '0;
      word_done <= 1'b0;
      in.credit <= 1'b0;
    end else begin
      if (in.push)
        wr_idx <= ~wr_idx;
      if (done)
        rd_idx <= ~rd_idx;
      cnt       <= cnt + 2'(in.push) - 2'(done);
      word_done <= done;
      in.credit <= done; // Entry freed
      if (start)
        mem_req <= 1'b1;
      else if (done)
        mem_req <= 1'b0; // Low for a cycle between writes
      if (acr_load)
        mem_addr <= {acr_value[31:2], 2'b00}; // Word aligned
      else if (done)
        mem_addr <= mem_addr + 32'd4;
    end
  end

  // Holding buffer and write data, stable through the request
  always_ff @(posedge CLK) begin
    if (in.push) begin
      hold_w[wr_idx] <= in.word;
      hold_l[wr_idx] <= in.lanes;
    end
    if (start) begin
      mem_wdata <= hold_w[rd_idx].lw;
      mem_be    <= hold_l[rd_idx];
    end
  end

endmodule

// File: design/word_fifo.sv
/* Word FIFO buffer
   Stores word and lane pairs, credits upstream per pop, spends credits downstream */
`timescale 1ns/1ps

module word_fifo import sdmac_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic CLK,
  input  logic RST_,
  dma_if.dst   in,
  dma_if.src   out,
  output logic fifo_empty,
  output logic fifo_full
);

  localparam int AW = $clog2(FIFO_DEPTH);

  dma_word_u     mem_w [FIFO_DEPTH]; // Word storage
  lane_t         mem_l [FIFO_DEPTH]; // Lane storage
  logic [AW-1:0] wr_ptr;             // Wraps naturally, depth is 2**AW
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic [1:0]    dn_credits;         // Master holds two words
  logic          pop;

  assign pop        = (count != '0) & (dn_credits != 2'd0);
  assign fifo_full  = (count == (AW + 1)'(FIFO_DEPTH));
  assign fifo_empty = (count == '0) & ~out.push; // Word on the wire counts

  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      dn_credits <= 2'd2;
      out.push   <= 1'b0;
      in.credit  <= 1'b0;
    end else begin
      if (in.push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count      <= count + (AW + 1)'(in.push) - (AW + 1)'(pop);
      dn_credits <= dn_credits - 2'(pop) + 2'(out.credit);
      out.push   <= pop;
      in.credit  <= pop; // Slot freed as the word leaves
    end
  end

  // Storage and output word
  always_ff @(posedge CLK) begin
    if (in.push) begin
      mem_w[wr_ptr] <= in.word;
      mem_l[wr_ptr] <= in.lanes;
    end
    if (pop) begin
      out.word  <= mem_w[rd_ptr];
      out.lanes <= mem_l[rd_ptr];
    end
  end

endmodule

// File: design/byte_packer.sv
/* Peripheral byte packer
   Packs bytes big-endian into words and pushes them on credits */
`timescale 1ns/1ps

module byte_packer import sdmac_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic       CLK,
  input  logic       RST_,
  input  logic       dma_ena,
  input  logic       flush_req,
  input  logic       per_valid,
  input  logic [7:0] per_byte,
  output logic       per_ready,
  output logic       packer_empty,
  dma_if.src         out
);

  localparam int CW = $clog2(FIFO_DEPTH + 1);

  dma_word_u     word_q;     // Bytes gathered so far
  dma_word_u     word_nx;    // Word as it goes out, empty lanes zeroed
  logic [1:0]    ptr;        // Bytes held
  lane_t         fill;       // Lanes covered by held bytes
  lane_t         push_lanes;
  logic [CW-1:0] credits;    // Free FIFO slots
  logic          take;       // Byte accepted this edge
  logic          full_push;
  logic          flush_push;
  logic          push_now;

  // Lanes fill from the top
  always_comb begin
    case (ptr)
      2'd0:    fill = 4'b0000;
      2'd1:    fill = 4'b1000;
      2'd2:    fill = 4'b1100;
      default: fill = 4'b1110;
    endcase
  end

  // Last byte needs a credit, earlier ones only need room in word_q
  assign per_ready  = dma_ena & ~flush_req & ((credits != '0) | (ptr != 2'd3));
  assign take       = per_valid & per_ready;
  assign full_push  = take & (ptr == 2'd3);
  assign flush_push = flush_req & (ptr != 2'd0) & (credits != '0); // Partial word
  assign push_now   = full_push | flush_push;
  assign push_lanes = full_push ? 4'b1111 : fill;

  // Nothing held and nothing on the wire
  assign packer_empty = (ptr == 2'd0) & ~out.push;

  always_comb begin
    word_nx = word_q;
    if (take)
      word_nx.b[2'd3 - ptr] = per_byte; // Fourth byte goes straight out
    for (int i = 0; i < 4; i++) begin
      if (!push_lanes[i])
        word_nx.b[i] = 8'h00; // Stale bytes from the last word
    end
  end

  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      ptr      <= 2'd0;
      credits  <= CW'(FIFO_DEPTH);
      out.push <= 1'b0;
    end else begin
      out.push <= push_now;
      credits  <= credits - CW'(push_now) + CW'(out.credit);
      if (push_now)
        ptr <= 2'd0;
      else if (take)
        ptr <= ptr + 2'd1;
    end
  end

  // Data path
  always_ff @(posedge CLK) begin
    if (take)
      word_q.b[2'd3 - ptr] <= per_byte;
    if (push_now) begin
      out.word  <= word_nx;
      out.lanes <= push_lanes;
    end
  end

endmodule

// File: design/sdmac_regs.sv
/* SDMAC CPU register block
   Address decode, control and status registers, strobes, flush and DSACK */
`timescale 1ns/1ps

module sdmac_regs import sdmac_pkg::*; (
  input  logic        CLK,
  input  logic        RST_,
  input  logic [7:0]  addr,
  input  logic        dmac_,
  input  logic        as_,
  input  logic        rw,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic        dsack_,
  output logic        int_,
  output logic        preset,
  output logic        dma_ena,
  output logic        flush_req,
  output logic        acr_load,
  output logic [31:0] acr_value,
  input  logic        fifo_empty,
  input  logic        fifo_full,
  input  logic        master_idle,
  input  logic        word_done,
  input  logic        packer_empty
);

  logic        sel;        // Chip selected with address strobe
  logic        hit;        // First edge of a selected cycle
  logic        cntr_wr;
  logic        acr_wr;
  logic        st_dma;     // Start DMA
  logic        sp_dma;     // Stop DMA
  logic        flush_stb;
  logic        clr_int;
  logic        path_empty; // Packer, FIFO and master all drained
  logic        inten;
  logic        int_f;      // Latched flush done
  logic [31:0] wtc;
  logic [31:0] cntr_rd;
  logic [31:0] istr_rd;
  logic [31:0] rd_mux;

  assign sel = ~dmac_ & ~as_;
  assign hit = sel & dsack_; // dsack_ still high, so not yet served

  // Writes decoded only with rw low
  assign cntr_wr = hit & ~rw & (addr == REG_CNTR);
  assign acr_wr  = hit & ~rw & (addr == REG_ACR);

  // Strobes act on any access to their offset
  assign st_dma    = hit & (addr == REG_ST_DMA);
  assign sp_dma    = hit & (addr == REG_SP_DMA);
  assign flush_stb = hit & (addr == REG_FLUSH);
  assign clr_int   = hit & (addr == REG_CLR_INT);

  assign path_empty = packer_empty & fifo_empty & master_idle;
  assign int_       = ~(int_f & inten); // INT_P is just INT_F for now

  // Bus termination, held until as_ goes away
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      dsack_ <= 1'b1;
    end else if (as_) begin
      dsack_ <= 1'b1;
    end else if (hit) begin
      dsack_ <= 1'b0;
    end
  end

  // Control register and DMA enable
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      inten   <= 1'b0;
      preset  <= 1'b0;
      dma_ena <= 1'b0;
    end else begin
      if (cntr_wr) begin
        inten  <= wdata[CNTR_INTEN];
        preset <= wdata[CNTR_PRESET]; // Drives peripheral reset pin
      end
      if (st_dma)
        dma_ena <= 1'b1;
      else if (sp_dma)
        dma_ena <= 1'b0;
    end
  end

  // Flush request and flush done interrupt
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      flush_req <= 1'b0;
      int_f     <= 1'b0;
    end else begin
      if (flush_stb)
        flush_req <= 1'b1;
      else if (flush_req && path_empty)
        flush_req <= 1'b0; // Whole path drained
      if (flush_req && path_empty)
        int_f <= 1'b1;     // Set beats clear on a tie
      else if (clr_int)
        int_f <= 1'b0;
    end
  end

  // Words transferred, restarts with each DMA start
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      wtc <= '0;
    end else if (st_dma) begin
      wtc <= '0;
    end else if (word_done) begin
      wtc <= wtc + 32'd1;
    end
  end

  // Address counter load, one pulse after the write
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_)
      acr_load <= 1'b0;
    else
      acr_load <= acr_wr;
  end

  always_ff @(posedge CLK) begin
    if (acr_wr)
      acr_value <= wdata;
  end

  // Read mux
  always_comb begin
    cntr_rd              = '0;
    cntr_rd[CNTR_INTEN]  = inten;
    cntr_rd[CNTR_PRESET] = preset;
    cntr_rd[CNTR_DMAENA] = dma_ena;
    istr_rd              = '0;
    istr_rd[ISTR_FE]     = fifo_empty;  // Live
    istr_rd[ISTR_FF]     = fifo_full;   // Live
    istr_rd[ISTR_INT_F]  = int_f;
    istr_rd[ISTR_INT_P]  = int_f;       // OR of latched sources
    case (addr)
      REG_WTC:  rd_mux = wtc;
      REG_CNTR: rd_mux = cntr_rd;
      REG_ISTR: rd_mux = istr_rd;
      default:  rd_mux = '0;            // Unmapped and strobes
    endcase
  end

  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_)
      rdata <= '0;
    else if (hit)
      rdata <= rd_mux; // Sampled with dsack_ going low
  end

endmodule

// File: design/dma_if.sv
/* Credit flow word link
   Source pushes word and lanes, destination pulses credit per freed slot */
`timescale 1ns/1ps

interface dma_if import sdmac_pkg::*; ();

  logic      push;   // One cycle per word
  dma_word_u word;   // Valid with push
  lane_t     lanes;  // Valid byte lanes of word
  logic      credit; // One slot freed at destination

  // Source side, never pushes without a credit
  modport src (
    output push,
    output word,
    output lanes,
    input  credit
  );

  // Destination side, always accepts a push
  modport dst (
    input  push,
    input  word,
    input  lanes,
    output credit
  );

endinterface

// File: design/sdmac_pkg.sv
/* SDMAC shared definitions
   Register map, register bit positions and the data word types */
package sdmac_pkg;

  // CPU register offsets
  localparam logic [7:0] REG_WTC     = 8'h04; // Words transferred, read
  localparam logic [7:0] REG_CNTR    = 8'h08; // Control, read/write
  localparam logic [7:0] REG_ACR     = 8'h0C; // Address counter, write
  localparam logic [7:0] REG_ST_DMA  = 8'h10; // Start strobe
  localparam logic [7:0] REG_FLUSH   = 8'h14; // Flush strobe
  localparam logic [7:0] REG_CLR_INT = 8'h18; // Clear interrupt strobe
  localparam logic [7:0] REG_ISTR    = 8'h1C; // Interrupt status, read
  localparam logic [7:0] REG_SP_DMA  = 8'h3C; // Stop strobe

  // Control register bits
  localparam int CNTR_INTEN  = 2;
  localparam int CNTR_PRESET = 4;
  localparam int CNTR_DMAENA = 8; // Read only, start/stop driven

  // Interrupt status bits
  localparam int ISTR_FE    = 0; // FIFO empty
  localparam int ISTR_FF    = 1; // FIFO full
  localparam int ISTR_INT_F = 4; // Flush done
  localparam int ISTR_INT_P = 7; // Any latched source pending

  // One valid bit per byte lane, 4'b1111 is a full word
  typedef logic [3:0] lane_t;

  // Data word as seen by the packer (bytes) and the bus master (longword)
  // b[3] holds the first byte received, so packing is big-endian
  typedef union packed {
    logic [31:0]     lw;
    logic [3:0][7:0] b;
  } dma_word_u;

endpackage
